// ==== include/rv_exec_defines.svh ====
`ifndef RV_EXEC_DEFINES_SVH
`define RV_EXEC_DEFINES_SVH

// ----------------------------------------
// datapath widths
// ----------------------------------------
`define XLEN        32  // data and instruction width
`define REG_ADDR_W  5
`define REG_COUNT   32

// ----------------------------------------
// op FIFO sizing
// ----------------------------------------
// depth must stay a power of two, pointers wrap on their own
`define OP_FIFO_DEPTH   4
`define OP_FIFO_PTR_W   2

`endif

// ==== hdl/rv_exec_pkg.sv ====
package rv_exec_pkg;

    // ----------------------------------------
    // major opcodes, inst[6:0]
    // ----------------------------------------
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // register-register
        OPC_OP_IMM = 7'b0010011,  // register-immediate
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // ----------------------------------------
    // ALU functions
    // ----------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10  // result is operand b, for LUI
    } alu_op_e;

endpackage

// ==== hdl/dec_op_if.sv ====
`timescale 1ns/10ps
`include "rv_exec_defines.svh"

// one decoded op with valid/ready handshake
interface dec_op_if
    import rv_exec_pkg::*;
();

    logic                   valid;
    logic                   ready;
    alu_op_e                alu_op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       imm;
    logic                   use_imm;  // operand b from imm, not rs2

    modport source (output valid, alu_op, rd, rs1, rs2, imm, use_imm,
                    input  ready);

    modport sink   (input  valid, alu_op, rd, rs1, rs2, imm, use_imm,
                    output ready);

endinterface

// ==== hdl/inst_decoder.sv ====
`timescale 1ns/10ps
`include "rv_exec_defines.svh"

module inst_decoder
    import rv_exec_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_valid,
    input  logic [`XLEN-1:0] inst,
    output logic             inst_ready,
    dec_op_if.source         out
);

    opcode_e                opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic                   legal;
    alu_op_e                dec_alu_op;
    logic [`XLEN-1:0]       dec_imm;
    logic [`REG_ADDR_W-1:0] dec_rs1;
    logic                   dec_use_imm;
    logic                   load;

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // ----------------------------------------
    // decode
    // ----------------------------------------
    always_comb begin
        legal       = 1'b0;
        dec_imm     = {{(`XLEN-12){inst[31]}}, inst[31:20]};  // I-type
        dec_rs1     = inst[19:15];
        dec_use_imm = 1'b0;

        case (funct3)
            3'b000:  dec_alu_op = (opcode == OPC_OP && inst[30]) ? ALU_SUB : ALU_ADD;
            3'b001:  dec_alu_op = ALU_SLL;
            3'b010:  dec_alu_op = ALU_SLT;
            3'b011:  dec_alu_op = ALU_SLTU;
            3'b100:  dec_alu_op = ALU_XOR;
            3'b101:  dec_alu_op = inst[30] ? ALU_SRA : ALU_SRL;
            3'b110:  dec_alu_op = ALU_OR;
            default: dec_alu_op = ALU_AND;
        endcase

        case (opcode)
            OPC_OP: begin
                // alternate funct7 only for SUB and SRA
                legal = (funct7 == 7'b0000000) ||
                        (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OP_IMM: begin
                dec_use_imm = 1'b1;
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);  // SLLI
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    legal = 1'b1;
                end
            end
            OPC_LUI: begin
                legal       = 1'b1;
                dec_alu_op  = ALU_PASS_B;
                dec_imm     = {inst[31:12], 12'b0};  // U-type
                dec_rs1     = '0;                    // operand a reads x0
                dec_use_imm = 1'b1;
            end
            default: legal = 1'b0;  // dropped silently
        endcase
    end

    // ----------------------------------------
    // one-entry output register
    // ----------------------------------------
    assign inst_ready = !out.valid || out.ready;
    assign load       = inst_valid && inst_ready && legal;

    always_ff @(posedge clk) begin
        if (rst) begin
            out.valid <= 1'b0;
        end else if (inst_ready) begin
            out.valid <= inst_valid && legal;  // illegal words leave it empty
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out.alu_op  <= dec_alu_op;
            out.rd      <= inst[11:7];
            out.rs1     <= dec_rs1;
            out.rs2     <= inst[24:20];
            out.imm     <= dec_imm;
            out.use_imm <= dec_use_imm;
        end
    end

endmodule

// ==== hdl/op_fifo.sv ====
`timescale 1ns/10ps
`include "rv_exec_defines.svh"

module op_fifo
    import rv_exec_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    dec_op_if.sink   in,
    dec_op_if.source out
);

    // storage, one array per field
    alu_op_e                alu_op_mem  [`OP_FIFO_DEPTH];
    logic [`REG_ADDR_W-1:0] rd_mem      [`OP_FIFO_DEPTH];
    logic [`REG_ADDR_W-1:0] rs1_mem     [`OP_FIFO_DEPTH];
    logic [`REG_ADDR_W-1:0] rs2_mem     [`OP_FIFO_DEPTH];
    logic [`XLEN-1:0]       imm_mem     [`OP_FIFO_DEPTH];
    logic                   use_imm_mem [`OP_FIFO_DEPTH];

    logic [`OP_FIFO_PTR_W-1:0] wr_ptr;
    logic [`OP_FIFO_PTR_W-1:0] rd_ptr;
    logic [`OP_FIFO_PTR_W:0]   count;  // one extra bit to tell full from empty
    logic                      full;
    logic                      push;
    logic                      pop;

    assign full      = (count == (`OP_FIFO_PTR_W+1)'(`OP_FIFO_DEPTH));
    assign in.ready  = !full;
    assign out.valid = (count != '0);
    assign push      = in.valid && in.ready;
    assign pop       = out.valid && out.ready;

    // ----------------------------------------
    // pointers and count
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or both
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            alu_op_mem[wr_ptr]  <= in.alu_op;
            rd_mem[wr_ptr]      <= in.rd;
            rs1_mem[wr_ptr]     <= in.rs1;
            rs2_mem[wr_ptr]     <= in.rs2;
            imm_mem[wr_ptr]     <= in.imm;
            use_imm_mem[wr_ptr] <= in.use_imm;
        end
    end

    // head entry, no fall-through
    assign out.alu_op  = alu_op_mem[rd_ptr];
    assign out.rd      = rd_mem[rd_ptr];
    assign out.rs1     = rs1_mem[rd_ptr];
    assign out.rs2     = rs2_mem[rd_ptr];
    assign out.imm     = imm_mem[rd_ptr];
    assign out.use_imm = use_imm_mem[rd_ptr];

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/10ps
`include "rv_exec_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   we,
    input  logic [`REG_ADDR_W-1:0] wa,
    input  logic [`REG_ADDR_W-1:0] ra1,
    input  logic [`REG_ADDR_W-1:0] ra2,
    input  logic [`XLEN-1:0]       wd,
    output logic [`XLEN-1:0]       rd1,
    output logic [`XLEN-1:0]       rd2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // one write port, x0 never written
    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};  // start from all zeros
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // combinational reads
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== hdl/alu_exec.sv ====
`timescale 1ns/10ps
`include "rv_exec_defines.svh"

module alu_exec
    import rv_exec_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    dec_op_if.sink                 in,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data,
    input  logic                   wb_ready
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] result;
    logic [4:0]       shamt;
    logic             accept;

    // write back in the same cycle the op is taken, so no forwarding needed
    reg_file i_reg_file (
        .clk (clk),
        .rst (rst),
        .we  (accept),
        .wa  (in.rd),
        .ra1 (in.rs1),
        .ra2 (in.rs2),
        .wd  (result),
        .rd1 (op_a),
        .rd2 (rs2_val)
    );

    assign op_b  = in.use_imm ? in.imm : rs2_val;
    assign shamt = op_b[4:0];  // low 5 bits only

    // ----------------------------------------
    // ALU
    // ----------------------------------------
    always_comb begin
        case (in.alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SLT:    result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   result = {{(`XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = $unsigned($signed(op_a) >>> shamt);  // sign fill
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

    // ----------------------------------------
    // output stream register
    // ----------------------------------------
    assign in.ready = !wb_valid || wb_ready;  // slot free or draining
    assign accept   = in.valid && in.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (in.ready) begin
            wb_valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wb_rd   <= in.rd;
            wb_data <= result;  // computed value even for x0
        end
    end

endmodule

// ==== hdl/rv_exec_top.sv ====
`timescale 1ns/10ps
`include "rv_exec_defines.svh"

module rv_exec_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   inst_valid,
    input  logic [`XLEN-1:0]       inst,
    output logic                   inst_ready,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_rd,
    output logic [`XLEN-1:0]       wb_data,
    input  logic                   wb_ready
);

    dec_op_if dec_q ();   // decoder to FIFO
    dec_op_if fifo_q ();  // FIFO to executor

    inst_decoder i_inst_decoder (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .out        (dec_q)
    );

    op_fifo i_op_fifo (
        .clk (clk),
        .rst (rst),
        .in  (dec_q),
        .out (fifo_q)
    );

    alu_exec i_alu_exec (
        .clk      (clk),
        .rst      (rst),
        .in       (fifo_q),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .wb_ready (wb_ready)
    );

endmodule

// ==== tb/rv_exec_asserts.sv ====
`timescale 1ns/10ps
`include "rv_exec_defines.svh"

// output stream checks, bound into the top level
module rv_exec_asserts (
    input logic                   clk,
    input logic                   rst,
    input logic                   wb_valid,
    input logic                   wb_ready,
    input logic [`REG_ADDR_W-1:0] wb_rd,
    input logic [`XLEN-1:0]       wb_data
);

    // a stalled result stays put
    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_rd) && $stable(wb_data)
    ) else $error("wb output changed while wb_ready was low");

    a_wb_reset: assert property (@(posedge clk) rst |=> !wb_valid)
        else $error("wb_valid high in the cycle after reset");

endmodule

bind rv_exec_top rv_exec_asserts i_rv_exec_asserts (
    .clk      (clk),
    .rst      (rst),
    .wb_valid (wb_valid),
    .wb_ready (wb_ready),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
);

// ==== tb/rv_exec_tb.sv ====
`timescale 1ns/10ps
`include "rv_exec_defines.svh"

module rv_exec_tb
    import rv_exec_pkg::*;
();

    logic                   clk = 1'b0;
    logic                   rst = 1'b1;
    logic                   inst_valid = 1'b0;
    logic [`XLEN-1:0]       inst = '0;
    logic                   inst_ready;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;
    logic                   wb_ready = 1'b1;

    logic [`XLEN-1:0]       model_regs [`REG_COUNT] = '{default: '0};
    logic [`XLEN-1:0]       inst_q [$];
    logic [`REG_ADDR_W-1:0] exp_rd_q [$];
    logic [`XLEN-1:0]       exp_data_q [$];
    logic [31:0]            stim_lfsr = 32'd31;
    logic [31:0]            ready_lfsr = 32'd31;
    logic                   random_ready = 1'b0;
    int                     errors, tests_passed, tests_failed, queued_total, cycles;

    // {alternate funct7, funct3} for each function
    localparam logic [3:0] op_sel [10] = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3,
                                           4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
    localparam logic [3:0] imm_sel [9] = '{4'h0, 4'h2, 4'h3, 4'h4, 4'h6,
                                           4'h7, 4'h1, 4'h5, 4'hd};

    rv_exec_top i_rv_exec_top (.*);

    always #5 clk = ~clk;

    // ----------------------------------------
    // random numbers and instruction encoding
    // ----------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hb4bc_d35c) : (s >> 1);  // Galois form
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], stim_lfsr[0]};  // one step per bit
            stim_lfsr = lfsr_step(stim_lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                                input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [2:0] f3,
                                                input logic [4:0] rd, rs1);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] u_type_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic logic [31:0] op_word(input int f, input logic [4:0] rd, rs1, rs2);
        return r_type_word(op_sel[f][3] ? 7'h20 : 7'h00, op_sel[f][2:0], rd, rs1, rs2);
    endfunction

    // negative immediate, or shift amount with funct7
    function automatic logic [31:0] imm_word(input int f, input logic [4:0] rd, rs1);
        logic [11:0] imm;
        if (imm_sel[f][1:0] == 2'b01) begin
            imm = {imm_sel[f][3] ? 7'h20 : 7'h00, 5'(take_bits(5))};
        end else begin
            imm = {1'b1, 11'(take_bits(11))};
        end
        return i_type_word(imm, imm_sel[f][2:0], rd, rs1);
    endfunction

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic void model_exec(input logic [`XLEN-1:0] w,
                                       ref logic [`XLEN-1:0] regs [`REG_COUNT],
                                       output logic legal,
                                       output logic [`REG_ADDR_W-1:0] rd,
                                       output logic [`XLEN-1:0] res);
        logic [2:0]       f3;
        logic [6:0]       f7;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic             alt;  // bit 30 picks SUB or SRA
        f3    = w[14:12];
        f7    = w[31:25];
        rd    = w[11:7];
        a     = regs[w[19:15]];
        legal = 1'b1;
        res   = '0;
        if (w[6:0] == 7'b0110111) begin
            res = {w[31:12], 12'h000};
        end else if (w[6:0] == 7'b0110011 || w[6:0] == 7'b0010011) begin
            if (w[5]) begin
                b     = regs[w[24:20]];
                alt   = (f7 == 7'h20);
                legal = (f7 == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
            end else begin
                b     = {{20{w[31]}}, w[31:20]};
                alt   = (f3 == 3'd5) && (f7 == 7'h20);
                legal = (f3 != 3'd1 && f3 != 3'd5) || (f7 == 7'h00) || alt;
            end
            case (f3)
                3'd0:    res = alt ? a - b : a + b;
                3'd1:    res = a << b[4:0];
                3'd2:    res = {31'd0, $signed(a) < $signed(b)};
                3'd3:    res = {31'd0, a < b};
                3'd4:    res = a ^ b;
                3'd5: begin
                    if (alt) res = $signed(a) >>> b[4:0];
                    else res = a >> b[4:0];
                end
                3'd6:    res = a | b;
                default: res = a & b;
            endcase
        end else begin
            legal = 1'b0;
        end
        if (legal && rd != '0) regs[rd] = res;  // x0 stays zero
    endfunction

    // ----------------------------------------
    // driving and test bookkeeping
    // ----------------------------------------
    task automatic add_word(input logic [`XLEN-1:0] w);
        inst_q.push_back(w);
        queued_total++;
    endtask

    task automatic send_word(input logic [`XLEN-1:0] w);
        logic                   legal;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       res;
        inst_valid = 1'b1;
        inst       = w;
        while (!inst_ready) @(negedge clk);
        model_exec(w, model_regs, legal, rd, res);  // taken at the next rising edge
        if (legal) begin
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(res);
        end
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic run_queue(input logic gaps);
        logic [`XLEN-1:0] w;
        while (inst_q.size() != 0) begin
            w = inst_q.pop_front();
            if (gaps && take_bits(2) == 0) @(negedge clk);  // idle input cycle
            send_word(w);
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        while (exp_rd_q.size() != 0) @(negedge clk);
        repeat (8) @(negedge clk);  // room for a stray result
        if (errors == start_errors) begin
            tests_passed++;
            $display("test %-9s ok", name);
        end else begin
            tests_failed++;
            $display("test %-9s failed, %0d errors", name, errors - start_errors);
        end
    endtask

    // ----------------------------------------
    // output side and comparison
    // ----------------------------------------
    always @(negedge clk) begin : compare
        logic [`REG_ADDR_W-1:0] exp_rd;
        logic [`XLEN-1:0]       exp_data;
        wb_ready = random_ready ? ready_lfsr[0] : 1'b1;
        if (random_ready) ready_lfsr = lfsr_step(ready_lfsr);
        if (!rst && wb_valid && wb_ready) begin
            if (exp_rd_q.size() == 0) begin
                $display("result x%0d = %h at %0t arrived with nothing expected",
                         wb_rd, wb_data, $time);
                errors++;
            end else begin
                exp_rd   = exp_rd_q.pop_front();
                exp_data = exp_data_q.pop_front();
                assert (wb_rd === exp_rd) else begin
                    $display("** Error at %0t: wb_rd expected %0d, got %0d",
                             $time, exp_rd, wb_rd);
                    errors++;
                end
                assert (wb_data === exp_data) else begin
                    $display("** Error at %0t: wb_data expected %h, got %h",
                             $time, exp_data, wb_data);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 20 * queued_total + 200) begin
            $display("timeout after %0d cycles with results still missing", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        logic [`REG_ADDR_W-1:0] rd, rs1, rs2;
        int                     base;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        base = errors;  // LUI and ADDI per register, then read back in pairs
        for (int r = 1; r < 32; r++) begin
            add_word(u_type_word(20'(take_bits(20)), 5'(r)));
            add_word(i_type_word(12'(take_bits(12)), 3'd0, 5'(r), 5'(r)));
        end
        for (int r = 1; r < 31; r++) add_word(op_word(0, 5'd0, 5'(r), 5'(r + 1)));
        run_queue(1'b0);
        finish_test("lui_addi", base);

        base = errors;
        for (int i = 0; i < 40; i++) begin
            rd  = 5'(take_bits(5));
            rs1 = 5'(take_bits(5));
            rs2 = (i >= 30) ? rs1 : 5'(take_bits(5));  // last round uses equal operands
            add_word(op_word(i % 10, rd, rs1, rs2));
        end
        run_queue(1'b0);
        finish_test("op", base);

        base = errors;
        for (int i = 0; i < 36; i++) begin
            rd  = 5'(take_bits(5));
            rs1 = 5'(take_bits(5));
            add_word(imm_word(i % 9, rd, rs1));
        end
        run_queue(1'b0);
        finish_test("op_imm", base);

        base = errors;  // x0 as target, then x0 as source
        add_word(i_type_word(12'h7ff, 3'd0, 5'd0, 5'd5));
        add_word(u_type_word(20'habcde, 5'd0));
        add_word(op_word(0, 5'd0, 5'd3, 5'd4));
        add_word(op_word(0, 5'd7, 5'd0, 5'd0));
        add_word(i_type_word(12'h005, 3'd6, 5'd8, 5'd0));
        run_queue(1'b0);
        finish_test("x0", base);

        base = errors;
        add_word(i_type_word(12'h123, 3'd0, 5'd10, 5'd0));
        add_word(32'h0000_2083);                                 // load
        add_word(32'h0001_0517);                                 // auipc
        add_word(op_word(0, 5'd11, 5'd10, 5'd10));
        add_word(r_type_word(7'h01, 3'd0, 5'd12, 5'd10, 5'd10));  // mul
        add_word(r_type_word(7'h20, 3'd4, 5'd13, 5'd10, 5'd10));
        add_word(i_type_word(12'h405, 3'd1, 5'd14, 5'd10));       // slli, bad funct7
        add_word(op_word(7, 5'd15, 5'd11, 5'd10));
        run_queue(1'b0);
        finish_test("illegal", base);

        base = errors;
        random_ready = 1'b1;
        for (int i = 0; i < 200; i++) begin
            rd  = 5'(take_bits(5));
            rs1 = 5'(take_bits(5));
            rs2 = 5'(take_bits(5));
            case (take_bits(2))
                0:       add_word(op_word(int'(take_bits(4) % 10), rd, rs1, rs2));
                1:       add_word(imm_word(int'(take_bits(4) % 9), rd, rs1));
                2:       add_word(u_type_word(20'(take_bits(20)), rd));
                default: add_word(r_type_word(7'h01, 3'(take_bits(3)), rd, rs1, rs2));
            endcase
        end
        run_queue(1'b1);
        finish_test("random", base);
        random_ready = 1'b0;

        $display("tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+include
hdl/rv_exec_pkg.sv
hdl/dec_op_if.sv
hdl/inst_decoder.sv
hdl/op_fifo.sv
hdl/reg_file.sv
hdl/alu_exec.sv
hdl/rv_exec_top.sv
tb/rv_exec_asserts.sv
tb/rv_exec_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f all.f --top-module rv_exec_tb -o rv_exec_sim

out=$(./obj_dir/rv_exec_sim)
echo "$out"
echo "$out" | grep -qx "TESTBENCH PASSED"
